// File: source/DecodePkg.sv
`default_nettype none

package DecodePkg;

	// ======================================================================
	// Encodings
	// ======================================================================

	// Major opcodes, held in the low seven bits of every instruction
	typedef enum logic [6:0]
	{
		OP_NOP  = 7'h00,
		OP_ADD  = 7'h02,
		OP_ADDI = 7'h04,
		OP_ANDI = 7'h08,
		OP_ORI  = 7'h09,
		OP_LDI  = 7'h0A,
		OP_MOV  = 7'h0C,
		OP_LDX  = 7'h10,
		OP_STX  = 7'h11,
		OP_ST   = 7'h12,
		OP_BR   = 7'h20,
		OP_DBRA = 7'h21,
		OP_RTD  = 7'h24,
		OP_FLT3 = 7'h30,
		OP_PFX  = 7'h7C
	} opcode_t;

	// Function codes of the indexed load and store forms
	typedef enum logic [6:0]
	{
		FN_LDX   = 7'h00,
		FN_LDCTX = 7'h01,
		FN_STX   = 7'h08,
		FN_STCTX = 7'h09
	} func_t;

	// Operating modes, each of which owns a stack pointer
	typedef enum logic [1:0]
	{
		OM_USER    = 2'd0,
		OM_SUPER   = 2'd1,
		OM_HYPER   = 2'd2,
		OM_MACHINE = 2'd3
	} operating_mode_t;

	// ======================================================================
	// Instruction fields and sizes
	// ======================================================================

	localparam int InstrWidth = 48;
	localparam int OpcodeLsb = 0;
	localparam int OpcodeMsb = 6;
	localparam int RtLsb = 7;
	localparam int RtMsb = 12;
	localparam int RaLsb = 13;
	localparam int RaMsb = 18;
	localparam int RaNegBit = 19;
	localparam int FuncLsb = 40;
	localparam int FuncMsb = 46;
	// Set on a MOV that crosses register banks
	localparam int AltBit = 47;
	// A prefix carries everything above its opcode
	localparam int PayloadLsb = 7;
	localparam int PayloadMsb = 47;
	// Immediate that an ordinary instruction carries itself
	localparam int OwnImmLsb = 20;
	localparam int OwnImmMsb = 47;
	localparam int ImmWidth = 41;

	localparam int ARegWidth = 9;

	// Special architectural registers
	localparam int RegStackPtr = 32;
	localparam int RegCtx = 40;
	localparam int RegRtdBase = 40;
	localparam int RegLoopCount = 55;
	localparam int RegAlias = 31;

	// Flow control on both sides of the stage
	localparam int InQueueDepth = 2;
	localparam int QueueIdxWidth = $clog2(InQueueDepth);
	localparam int QueueCntWidth = $clog2(InQueueDepth + 1);
	localparam int OutCredits = 4;
	localparam int CreditWidth = $clog2(OutCredits + 1);

	// Register 31 is an alias of the current mode's stack pointer, except
	// on a bank-to-bank MOV where it names the real register
	function automatic logic [ARegWidth-1:0] mapStackAlias(
		input logic [ARegWidth-1:0] regNum,
		input operating_mode_t om,
		input logic [InstrWidth-1:0] instr
	);
		logic isAltMove;
		begin
			isAltMove = (instr[OpcodeMsb:OpcodeLsb] == OP_MOV) && instr[AltBit];
			if (regNum == ARegWidth'(RegAlias) && !isAltMove)
				mapStackAlias = ARegWidth'(RegStackPtr) + ARegWidth'(om);
			else
				mapStackAlias = regNum;
		end
	endfunction

endpackage

`default_nettype wire

// File: source/DecodeImmediate.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeImmediate
	import DecodePkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic [InstrWidth-1:0] headInstr,
	input  wire logic                  drain,
	output logic                       hasImma,
	output logic      [ImmWidth-1:0]   imm
);

	opcode_t headOpcode;
	logic headIsPrefix;
	logic impliedImm;
	logic pendingValid;
	logic [ImmWidth-1:0] pendingPayload;

	assign headOpcode = opcode_t'(headInstr[OpcodeMsb:OpcodeLsb]);
	assign headIsPrefix = (headOpcode == OP_PFX);

	// These opcodes take an immediate from their own upper bits
	always_comb
	begin
		case (headOpcode)
			OP_ADDI, OP_ANDI, OP_ORI, OP_LDI:
				impliedImm = 1'b1;
			default:
				impliedImm = 1'b0;
		endcase
	end

	// ======================================================================
	// Pending prefix
	// ======================================================================

	// Set while a drained prefix waits for the instruction it belongs to
	always_ff @(posedge clk)
	begin
		if (reset)
			pendingValid <= 1'b0;
		else if (drain)
			// A prefix arms the flag, anything else consumes it
			pendingValid <= headIsPrefix;
	end

	// A later prefix simply overwrites an earlier one
	always_ff @(posedge clk)
	begin
		if (drain && headIsPrefix)
			pendingPayload <= headInstr[PayloadMsb:PayloadLsb];
	end

	// ======================================================================
	// Immediate selection for the head
	// ======================================================================

	assign hasImma = pendingValid || impliedImm;

	always_comb
	begin
		if (pendingValid)
			imm = pendingPayload;
		else if (impliedImm)
			// Own immediate is zero extended to the full width
			imm = ImmWidth'(headInstr[OwnImmMsb:OwnImmLsb]);
		else
			imm = '0;
	end

endmodule

`default_nettype wire

// File: source/DecodeRa.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeRa
	import DecodePkg::*;
(
	input  wire operating_mode_t       om,
	input  wire logic [InstrWidth-1:0] instr,
	input  wire logic                  hasImma,
	output logic      [ARegWidth-1:0]  ra,
	output logic                       raz,
	output logic                       ran
);

	opcode_t opcode;
	func_t func;
	logic [ARegWidth-1:0] raField;
	logic [2:0] rtdSel;
	logic [ARegWidth-1:0] raBase;

	assign opcode = opcode_t'(instr[OpcodeMsb:OpcodeLsb]);
	assign func = func_t'(instr[FuncMsb:FuncLsb]);
	assign raField = ARegWidth'(instr[RaMsb:RaLsb]);
	// Return-and-deallocate only looks at the bottom three bits
	assign rtdSel = instr[RaLsb+2:RaLsb];

	// ======================================================================
	// Base register selection, first matching rule wins
	// ======================================================================

	always_comb
	begin
		if (hasImma)
		begin
			// The Ra slot is taken by the immediate operand
			raBase = '0;
		end
		else
		begin
			case (opcode)
				OP_RTD:
				begin
					// Zero selects no register, others pick 41 to 47
					if (rtdSel == 3'd0)
						raBase = '0;
					else
						raBase = ARegWidth'(RegRtdBase) + ARegWidth'(rtdSel);
				end
				OP_DBRA:
					raBase = ARegWidth'(RegLoopCount);
				OP_LDX:
				begin
					if (func == FN_LDCTX)
						raBase = ARegWidth'(RegCtx);
					else
						raBase = raField;
				end
				OP_STX:
				begin
					if (func == FN_STCTX)
						raBase = ARegWidth'(RegCtx);
					else
						raBase = raField;
				end
				default:
					raBase = raField;
			endcase
		end
	end

	// Stack pointer alias is applied after the special cases
	assign ra = mapStackAlias(raBase, om, instr);
	assign raz = (ra == '0);
	assign ran = instr[RaNegBit];

endmodule

`default_nettype wire

// File: source/DecodeRt.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeRt
	import DecodePkg::*;
(
	input  wire operating_mode_t       om,
	input  wire logic [InstrWidth-1:0] instr,
	output logic      [ARegWidth-1:0]  rt,
	output logic                       rtz
);

	opcode_t opcode;
	logic [ARegWidth-1:0] rtField;
	logic [ARegWidth-1:0] rtBase;

	assign opcode = opcode_t'(instr[OpcodeMsb:OpcodeLsb]);
	assign rtField = ARegWidth'(instr[RtMsb:RtLsb]);

	// ======================================================================
	// Target register selection
	// ======================================================================

	always_comb
	begin
		case (opcode)
			// Stores and branches write nothing, so the target is r0
			OP_ST, OP_STX, OP_BR, OP_NOP:
				rtBase = '0;
			// Decrement-and-branch updates the loop counter in place
			OP_DBRA:
				rtBase = ARegWidth'(RegLoopCount);
			default:
				rtBase = rtField;
		endcase
	end

	// Same stack pointer aliasing as the source side
	assign rt = mapStackAlias(rtBase, om, instr);

	// Zero flag lets later stages skip the register write
	assign rtz = (rt == '0);

endmodule

`default_nettype wire

// File: source/DecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeStage
	import DecodePkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  inValid,
	input  wire logic [InstrWidth-1:0] instr,
	input  wire operating_mode_t       om,
	input  wire logic                  outCredit,
	output logic                       inCredit,
	output logic                       outValid,
	output opcode_t                    outOpcode,
	output func_t                      outFunc,
	output logic      [ARegWidth-1:0]  outRa,
	output logic                       outRaz,
	output logic                       outRan,
	output logic      [ARegWidth-1:0]  outRt,
	output logic                       outRtz,
	output logic                       outHasImm,
	output logic      [ImmWidth-1:0]   outImm
);

	// Queue storage for the instruction and the mode it was sent in
	logic [InstrWidth-1:0] qInstr [InQueueDepth];
	operating_mode_t qMode [InQueueDepth];
	logic [QueueIdxWidth-1:0] wrPtr;
	logic [QueueIdxWidth-1:0] rdPtr;
	logic [QueueCntWidth-1:0] qCount;

	logic [CreditWidth-1:0] creditCount;

	logic [InstrWidth-1:0] headInstr;
	operating_mode_t headMode;
	logic headValid;
	logic headIsPrefix;
	logic drain;
	logic emit;

	logic hasImma;
	logic [ImmWidth-1:0] imm;
	logic [ARegWidth-1:0] ra;
	logic raz;
	logic ran;
	logic [ARegWidth-1:0] rt;
	logic rtz;

	// ======================================================================
	// Input queue
	// ======================================================================

	assign headInstr = qInstr[rdPtr];
	assign headMode = qMode[rdPtr];
	assign headValid = (qCount != '0);
	assign headIsPrefix = (headInstr[OpcodeMsb:OpcodeLsb] == OP_PFX);

	// A prefix never needs a downstream credit, an ordinary instruction does
	assign drain = headValid && (headIsPrefix || creditCount != '0);
	assign emit = drain && !headIsPrefix;

	// The upstream only sends while it holds a credit, so there is always room
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			qInstr[wrPtr] <= instr;
			qMode[wrPtr] <= om;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			qCount <= '0;
		end
		else
		begin
			if (inValid)
				wrPtr <= wrPtr + 1'b1;
			if (drain)
				rdPtr <= rdPtr + 1'b1;
			qCount <= qCount + QueueCntWidth'(inValid) - QueueCntWidth'(drain);
		end
	end

	// ======================================================================
	// Credits on both sides
	// ======================================================================

	// Spend and return may land in the same cycle and then cancel out
	always_ff @(posedge clk)
	begin
		if (reset)
			creditCount <= CreditWidth'(OutCredits);
		else
			creditCount <= creditCount + CreditWidth'(outCredit) - CreditWidth'(emit);
	end

	// Every drained entry frees one slot upstream, prefixes included
	always_ff @(posedge clk)
	begin
		if (reset)
			inCredit <= 1'b0;
		else
			inCredit <= drain;
	end

	// ======================================================================
	// Decoders
	// ======================================================================

	DecodeImmediate u_DecodeImmediate
	(
		.clk(clk),
		.reset(reset),
		.headInstr(headInstr),
		.drain(drain),
		.hasImma(hasImma),
		.imm(imm)
	);

	DecodeRa u_DecodeRa
	(
		.om(headMode),
		.instr(headInstr),
		.hasImma(hasImma),
		.ra(ra),
		.raz(raz),
		.ran(ran)
	);

	DecodeRt u_DecodeRt
	(
		.om(headMode),
		.instr(headInstr),
		.rt(rt),
		.rtz(rtz)
	);

	// ======================================================================
	// Output register
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= emit;
	end

	// Result fields only load on a decoded instruction
	always_ff @(posedge clk)
	begin
		if (emit)
		begin
			outOpcode <= opcode_t'(headInstr[OpcodeMsb:OpcodeLsb]);
			outFunc <= func_t'(headInstr[FuncMsb:FuncLsb]);
			outRa <= ra;
			outRaz <= raz;
			outRan <= ran;
			outRt <= rt;
			outRtz <= rtz;
			outHasImm <= hasImma;
			outImm <= imm;
		end
	end

endmodule

`default_nettype wire

// File: verification/ClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module ClockGen
(
	input  wire logic resetRequest,
	output logic      clk,
	output logic      reset
);

	// Half of the 20 ns clock period
	localparam int HalfPeriod = 10;
	localparam int ResetCycles = 16;

	logic initReset;

	initial
	begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// Power-on reset covers the first sixteen rising edges
	initial
	begin
		initReset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		initReset <= 1'b0;
	end

	// The testbench may request another reset at any later point
	assign reset = initReset || resetRequest;

endmodule

`default_nettype wire

// File: verification/DecodeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeChecker
	import DecodePkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  inValid,
	input  wire logic                  inCredit,
	input  wire logic                  outCredit,
	input  wire logic                  outValid,
	input  wire opcode_t               outOpcode,
	input  wire func_t                 outFunc,
	input  wire logic [ARegWidth-1:0]  outRa,
	input  wire logic                  outRaz,
	input  wire logic                  outRan,
	input  wire logic [ARegWidth-1:0]  outRt,
	input  wire logic                  outRtz,
	input  wire logic                  outHasImm,
	input  wire logic [ImmWidth-1:0]   outImm,
	input  wire logic                  expPush,
	input  wire logic [76:0]           expData,
	output int                         errorCount,
	output int                         pendingCount,
	output int                         outCount,
	output int                         inCreditCount,
	output int                         resultTotal
);

	// Records hold opcode, func, ra, raz, ran, rt, rtz, hasImm and imm from the top down
	logic [76:0] expQueue [$];
	int inValidCount;
	int returned;

	initial
	begin
		errorCount = 0;
		resultTotal = 0;
		pendingCount = 0;
		outCount = 0;
		inCreditCount = 0;
		inValidCount = 0;
		returned = 0;
	end

	task automatic compareField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		if (expVal !== actVal)
		begin
			errorCount++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
		end
	endtask

	// ======================================================================
	// Sampling on every rising edge
	// ======================================================================

	always @(posedge clk)
	begin : sample
		logic [76:0] rec;
		if (reset)
		begin
			// Everything in flight is lost on reset, and the window refills
			expQueue.delete();
			outCount = 0;
			inCreditCount = 0;
			inValidCount = 0;
			returned = 0;
		end
		else
		begin
			if (expPush)
				expQueue.push_back(expData);
			if (inValid)
				inValidCount++;
			if (outCredit)
				returned++;
			if (inCredit)
			begin
				inCreditCount++;
				if (inCreditCount > inValidCount)
				begin
					errorCount++;
					$display("At %0t the DUT returned more input credits than it got entries", $time);
				end
			end
			if (outValid)
			begin
				outCount++;
				resultTotal++;
				// Spending beyond the granted window means the counter leaks
				if (outCount > OutCredits + returned)
				begin
					errorCount++;
					$display("At %0t the DUT sent a result without a downstream credit", $time);
				end
				if (expQueue.size() == 0)
				begin
					errorCount++;
					$display("At %0t the DUT sent a result that nobody expected", $time);
				end
				else
				begin
					rec = expQueue.pop_front();
					compareField("outOpcode", 64'(rec[76:70]), 64'(outOpcode));
					compareField("outFunc", 64'(rec[69:63]), 64'(outFunc));
					compareField("outRa", 64'(rec[62:54]), 64'(outRa));
					compareField("outRaz", 64'(rec[53]), 64'(outRaz));
					compareField("outRan", 64'(rec[52]), 64'(outRan));
					compareField("outRt", 64'(rec[51:43]), 64'(outRt));
					compareField("outRtz", 64'(rec[42]), 64'(outRtz));
					compareField("outHasImm", 64'(rec[41]), 64'(outHasImm));
					compareField("outImm", 64'(rec[40:0]), 64'(outImm));
				end
			end
		end
		pendingCount = expQueue.size();
	end

endmodule

`default_nettype wire

// File: verification/tb_DecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_DecodeStage
	import DecodePkg::*;
();

	// Each instruction is given ten cycles, plus slack for resets and drains
	localparam int TimeoutCycles = 400 * 10 + 200;
	localparam int InputSkew = 2;

	logic clk;
	logic reset;
	logic resetRequest;
	logic inValid;
	logic [InstrWidth-1:0] instr;
	operating_mode_t om;
	logic outCredit;
	logic inCredit;
	logic outValid;
	opcode_t outOpcode;
	func_t outFunc;
	logic [ARegWidth-1:0] outRa;
	logic outRaz;
	logic outRan;
	logic [ARegWidth-1:0] outRt;
	logic outRtz;
	logic outHasImm;
	logic [ImmWidth-1:0] outImm;

	logic expPush;
	logic [76:0] expData;
	int errorCount;
	int pendingCount;
	int outCount;
	int inCreditCount;
	int resultTotal;

	logic [31:0] rngState = 32'd35;
	logic [31:0] delayState = 32'd35;
	int cycleCount = 0;
	int sentCount = 0;
	int totalSent = 0;
	int creditsBack = 0;
	int tbErrors = 0;
	int markResults = 0;
	int markErrors = 0;
	int totalErrors;
	logic holdCredits;
	logic modelPending;
	logic [ImmWidth-1:0] modelPayload;
	int returnDue [$];

	ClockGen u_ClockGen
	(
		.resetRequest(resetRequest),
		.clk(clk),
		.reset(reset)
	);

	DecodeStage u_DecodeStage
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.instr(instr),
		.om(om),
		.outCredit(outCredit),
		.inCredit(inCredit),
		.outValid(outValid),
		.outOpcode(outOpcode),
		.outFunc(outFunc),
		.outRa(outRa),
		.outRaz(outRaz),
		.outRan(outRan),
		.outRt(outRt),
		.outRtz(outRtz),
		.outHasImm(outHasImm),
		.outImm(outImm)
	);

	DecodeChecker u_DecodeChecker
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inCredit(inCredit),
		.outCredit(outCredit),
		.outValid(outValid),
		.outOpcode(outOpcode),
		.outFunc(outFunc),
		.outRa(outRa),
		.outRaz(outRaz),
		.outRan(outRan),
		.outRt(outRt),
		.outRtz(outRtz),
		.outHasImm(outHasImm),
		.outImm(outImm),
		.expPush(expPush),
		.expData(expData),
		.errorCount(errorCount),
		.pendingCount(pendingCount),
		.outCount(outCount),
		.inCreditCount(inCreditCount),
		.resultTotal(resultTotal)
	);

	// ======================================================================
	// Random numbers and instruction building
	// ======================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Only the main initial block draws from this stream
	function logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function int randBelow(input int n);
		logic [31:0] r;
		r = nextRandom();
		return int'(r % 32'(n));
	endfunction

	function operating_mode_t randomMode();
		logic [31:0] r;
		r = nextRandom();
		return operating_mode_t'(r[1:0]);
	endfunction

	// Every opcode except the prefix, implied-immediate ones at 2 to 5
	function automatic opcode_t opcodeAt(input int idx);
		case (idx)
			1: return OP_ADD;
			2: return OP_ADDI;
			3: return OP_ANDI;
			4: return OP_ORI;
			5: return OP_LDI;
			6: return OP_MOV;
			7: return OP_LDX;
			8: return OP_STX;
			9: return OP_ST;
			10: return OP_BR;
			11: return OP_DBRA;
			12: return OP_RTD;
			13: return OP_FLT3;
			default: return OP_NOP;
		endcase
	endfunction

	// Kind 1 is plain, 2 special registers, 3 register 31, 4 mixed with prefixes
	function logic [InstrWidth-1:0] buildInstr(input int kind);
		logic [31:0] hi;
		logic [31:0] lo;
		logic [InstrWidth-1:0] w;
		int pick;
		hi = nextRandom();
		lo = nextRandom();
		w = {hi[15:0], lo};
		pick = randBelow(6);
		case (kind)
			2:
			begin
				case (pick)
					0: w[OpcodeMsb:OpcodeLsb] = OP_RTD;
					1: w[OpcodeMsb:OpcodeLsb] = OP_DBRA;
					2:
					begin
						w[OpcodeMsb:OpcodeLsb] = OP_LDX;
						w[FuncMsb:FuncLsb] = FN_LDCTX;
					end
					3:
					begin
						w[OpcodeMsb:OpcodeLsb] = OP_STX;
						w[FuncMsb:FuncLsb] = FN_STCTX;
					end
					4: w[OpcodeMsb:OpcodeLsb] = OP_ST;
					default: w[OpcodeMsb:OpcodeLsb] = OP_BR;
				endcase
			end
			3:
			begin
				// The alternate bit stays random so both MOV forms appear
				w[OpcodeMsb:OpcodeLsb] = pick[0] ? OP_MOV : OP_ADD;
				w[RtMsb:RtLsb] = 6'd31;
				w[RaMsb:RaLsb] = 6'd31;
			end
			4:
			begin
				if (pick < 2)
					w[OpcodeMsb:OpcodeLsb] = OP_PFX;
				else if (pick < 4)
					w[OpcodeMsb:OpcodeLsb] = opcodeAt(2 + randBelow(4));
				else
					w[OpcodeMsb:OpcodeLsb] = opcodeAt(randBelow(14));
			end
			default:
				w[OpcodeMsb:OpcodeLsb] = opcodeAt(randBelow(14));
		endcase
		return w;
	endfunction

	// ======================================================================
	// Reference decode model
	// ======================================================================

	function automatic logic [76:0] decodeModel(input logic [InstrWidth-1:0] w,
		input operating_mode_t mode, input logic pending, input logic [ImmWidth-1:0] payload);
		logic [6:0] opc;
		logic [6:0] fn;
		logic implied;
		logic hasImm;
		logic [ImmWidth-1:0] imm;
		logic [2:0] sel;
		logic [ARegWidth-1:0] ra;
		logic [ARegWidth-1:0] rt;
		opc = w[6:0];
		fn = w[46:40];
		implied = (opc == OP_ADDI) || (opc == OP_ANDI) || (opc == OP_ORI) || (opc == OP_LDI);
		hasImm = pending || implied;
		if (pending)
			imm = payload;
		else if (implied)
			imm = {13'd0, w[47:20]};
		else
			imm = '0;
		sel = w[15:13];
		// Ra rules in priority order
		if (hasImm)
			ra = '0;
		else if (opc == OP_RTD)
			ra = (sel == 3'd0) ? 9'd0 : 9'(RegRtdBase) + 9'(sel);
		else if (opc == OP_DBRA)
			ra = 9'(RegLoopCount);
		else if ((opc == OP_LDX && fn == FN_LDCTX) || (opc == OP_STX && fn == FN_STCTX))
			ra = 9'(RegCtx);
		else
			ra = {3'd0, w[18:13]};
		if (opc == OP_ST || opc == OP_STX || opc == OP_BR || opc == OP_NOP)
			rt = '0;
		else if (opc == OP_DBRA)
			rt = 9'(RegLoopCount);
		else
			rt = {3'd0, w[12:7]};
		// A bank-to-bank MOV names the real register 31
		if (!(opc == OP_MOV && w[47]))
		begin
			if (ra == 9'(RegAlias))
				ra = 9'(RegStackPtr) + 9'(mode);
			if (rt == 9'(RegAlias))
				rt = 9'(RegStackPtr) + 9'(mode);
		end
		return {opc, fn, ra, ra == 9'd0, w[19], rt, rt == 9'd0, hasImm, imm};
	endfunction

	// ======================================================================
	// Credit tracking on both sides
	// ======================================================================

	always @(posedge clk)
	begin
		if (reset)
			creditsBack <= 0;
		else if (inCredit)
			creditsBack <= creditsBack + 1;
	end

	// Downstream hands a credit back 0 to 5 cycles after each result
	always @(posedge clk)
	begin : creditReturn
		logic allowReturn;
		logic inReset;
		allowReturn = !holdCredits;
		inReset = reset;
		if (inReset)
			returnDue.delete();
		else if (outValid)
		begin
			delayState = xorshift(delayState);
			returnDue.push_back(cycleCount + 1 + int'(delayState % 32'd6));
		end
		#InputSkew;
		if (!inReset && allowReturn && returnDue.size() != 0 && returnDue[0] <= cycleCount)
		begin
			void'(returnDue.pop_front());
			outCredit = 1'b1;
		end
		else
			outCredit = 1'b0;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("sim failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic nextCycle();
		@(posedge clk);
		#InputSkew;
	endtask

	// Holds off until an upstream credit is free, then sends one entry
	task automatic sendInstr(input logic [InstrWidth-1:0] word, input operating_mode_t mode);
		logic isPrefix;
		isPrefix = (word[OpcodeMsb:OpcodeLsb] == OP_PFX);
		while (sentCount - creditsBack >= InQueueDepth)
			nextCycle();
		instr = word;
		om = mode;
		inValid = 1'b1;
		expPush = !isPrefix;
		expData = decodeModel(word, mode, modelPending, modelPayload);
		if (isPrefix)
		begin
			modelPending = 1'b1;
			modelPayload = word[PayloadMsb:PayloadLsb];
		end
		else
			modelPending = 1'b0;
		sentCount++;
		totalSent++;
		nextCycle();
		inValid = 1'b0;
		expPush = 1'b0;
	endtask

	task automatic runTest(input int kind, input int count);
		logic [InstrWidth-1:0] word;
		operating_mode_t mode;
		for (int i = 0; i < count; i++)
		begin
			word = buildInstr(kind);
			// Register 31 tests walk through all four modes in turn
			mode = (kind == 3) ? operating_mode_t'(i[1:0]) : randomMode();
			repeat (randBelow(3))
				nextCycle();
			sendInstr(word, mode);
		end
	endtask

	task automatic waitIdle();
		while (pendingCount != 0 || returnDue.size() != 0)
			nextCycle();
		repeat (6)
			nextCycle();
		if (inCreditCount != sentCount)
		begin
			tbErrors++;
			$display("Input credits are off: %0d sent but %0d inCredit pulses",
				sentCount, inCreditCount);
		end
	endtask

	// With returns withheld exactly one credit window drains, two wait in the queue
	task automatic heldWindow();
		int startOut;
		startOut = outCount;
		holdCredits = 1'b1;
		for (int i = 0; i < 6; i++)
			sendInstr(buildInstr(1), randomMode());
		repeat (20)
			nextCycle();
		if (outCount - startOut != OutCredits || pendingCount != InQueueDepth)
		begin
			tbErrors++;
			$display("Stalled output is wrong: %0d results and %0d waiting while credits held",
				outCount - startOut, pendingCount);
		end
		holdCredits = 1'b0;
		waitIdle();
	endtask

	task automatic midRunReset();
		holdCredits = 1'b1;
		for (int i = 0; i < 5; i++)
			sendInstr(buildInstr(1), randomMode());
		repeat (10)
			nextCycle();
		resetRequest = 1'b1;
		sentCount = 0;
		modelPending = 1'b0;
		repeat (16)
			nextCycle();
		resetRequest = 1'b0;
		repeat (20)
			nextCycle();
		if (outCount != 0 || inCreditCount != 0)
		begin
			tbErrors++;
			$display("After reset the DUT gave %0d results and %0d credits with no input",
				outCount, inCreditCount);
		end
		heldWindow();
		runTest(1, 29);
		waitIdle();
	endtask

	task automatic finishTest(input int num, input string name);
		int errs;
		errs = errorCount + tbErrors;
		$display("Test %0d %s: %0d results, %0d errors", num, name,
			resultTotal - markResults, errs - markErrors);
		markResults = resultTotal;
		markErrors = errs;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial
	begin
		inValid = 1'b0;
		instr = '0;
		om = OM_USER;
		outCredit = 1'b0;
		resetRequest = 1'b0;
		holdCredits = 1'b0;
		expPush = 1'b0;
		expData = '0;
		modelPending = 1'b0;
		modelPayload = '0;
		repeat (2)
			@(posedge clk);
		wait (!reset);
		nextCycle();
		runTest(1, 120);
		waitIdle();
		finishTest(1, "ordinary fields");
		runTest(2, 60);
		waitIdle();
		finishTest(2, "special registers");
		runTest(3, 40);
		waitIdle();
		finishTest(3, "stack pointer alias");
		runTest(4, 80);
		waitIdle();
		finishTest(4, "prefix immediates");
		repeat (10)
			heldWindow();
		finishTest(5, "credit flow");
		midRunReset();
		finishTest(6, "reset in mid-run");
		totalErrors = errorCount + tbErrors;
		$display("Summary: 6 tests, %0d instructions, %0d results, %0d errors",
			totalSent, resultTotal, totalErrors);
		if (totalErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
source/DecodePkg.sv
source/DecodeImmediate.sv
source/DecodeRa.sv
source/DecodeRt.sv
source/DecodeStage.sv
verification/ClockGen.sv
verification/DecodeChecker.sv
verification/tb_DecodeStage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

TOP = tb_DecodeStage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f tb.f --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
